// File: flist.f
verilog/axi_wr_pkg.sv
verilog/sync_fifo.sv
verilog/burst_addr_gen.sv
verilog/wr_burst_ctrl.sv
verilog/axi_wr_slave.sv
verif/axi_wr_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AXI write slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=axi_wr_slave_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module axi_wr_slave_tb -f flist.f -o "$BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

// File: verif/axi_wr_slave_tb.sv
// Testbench for the AXI write slave, replays bursts from a case file and checks user beats and responses
module axi_wr_slave_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [axi_wr_pkg::ID_W-1:0]     awid;
    logic [axi_wr_pkg::ADDR_W-1:0]   awaddr;
    logic [axi_wr_pkg::LEN_W-1:0]    awlen;
    logic [axi_wr_pkg::SIZE_W-1:0]   awsize;
    logic [axi_wr_pkg::BURST_W-1:0]  awburst;
    logic                            awvalid;
    logic                            awready;
    logic [axi_wr_pkg::DATA_W-1:0]   wdata;
    logic [axi_wr_pkg::STRB_W-1:0]   wstrb;
    logic                            wlast;
    logic                            wvalid;
    logic                            wready;
    logic [axi_wr_pkg::ID_W-1:0]     bid;
    logic [axi_wr_pkg::RESP_W-1:0]   bresp;
    logic                            bvalid;
    logic                            bready;
    logic                            grant;
    logic                            we;
    logic                            last;
    logic [axi_wr_pkg::ADDR_W-1:0]   addr;
    logic [axi_wr_pkg::DATA_W-1:0]   data;
    logic [axi_wr_pkg::STRB_W-1:0]   strb;
    logic [axi_wr_pkg::ID_W-1:0]     id;
    logic [axi_wr_pkg::LEN_W-1:0]    len;
    logic [axi_wr_pkg::SIZE_W-1:0]   size;
    logic [axi_wr_pkg::BURST_W-1:0]  burst;

    // Raw words of the case file
    logic [31:0]                     case_words [1024];
    // Stimulus per AXI channel in file order
    axi_wr_pkg::aw_entry_t           aw_stim_q [$];
    axi_wr_pkg::w_entry_t            w_stim_q [$];
    // Expected user beats and responses
    logic [axi_wr_pkg::ADDR_W-1:0]   exp_addr_q [$];
    logic [axi_wr_pkg::DATA_W-1:0]   exp_data_q [$];
    logic [axi_wr_pkg::STRB_W-1:0]   exp_strb_q [$];
    logic                            exp_last_q [$];
    logic [axi_wr_pkg::ID_W-1:0]     exp_id_q [$];
    logic [axi_wr_pkg::LEN_W-1:0]    exp_len_q [$];
    logic [axi_wr_pkg::SIZE_W-1:0]   exp_size_q [$];
    logic [axi_wr_pkg::BURST_W-1:0]  exp_burst_q [$];
    axi_wr_pkg::b_entry_t            exp_resp_q [$];
    int                              n_cases;
    int                              timeout_limit = 1000;
    int                              cycle_cnt = 0;
    bit                              aw_stall_seen = 1'b0;
    bit                              w_stall_seen = 1'b0;

    // 40 ns clock
    always #20 clk = ~clk;

    axi_wr_slave axi_wr_slave_inst (
        .clk     (clk),     .rst_n   (rst_n),
        .awid    (awid),    .awaddr  (awaddr),  .awlen   (awlen),
        .awsize  (awsize),  .awburst (awburst), .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wlast   (wlast),
        .wvalid  (wvalid),  .wready  (wready),
        .bid     (bid),     .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .grant   (grant),   .we      (we),      .last    (last),
        .addr    (addr),    .data    (data),    .strb    (strb),
        .id      (id),      .len     (len),     .size    (size),    .burst   (burst)
    );

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what);
        fail_run($sformatf("ERROR at time %0d ns: %s", $time, what));
    endtask

    task automatic check_beat(
        input logic [axi_wr_pkg::ADDR_W-1:0]  got_addr,
        input logic [axi_wr_pkg::ADDR_W-1:0]  exp_addr,
        input logic [axi_wr_pkg::DATA_W-1:0]  got_data,
        input logic [axi_wr_pkg::DATA_W-1:0]  exp_data,
        input logic [axi_wr_pkg::STRB_W-1:0]  got_strb,
        input logic [axi_wr_pkg::STRB_W-1:0]  exp_strb,
        input logic                           got_last,
        input logic                           exp_last,
        input logic [axi_wr_pkg::ID_W-1:0]    got_id,
        input logic [axi_wr_pkg::ID_W-1:0]    exp_id,
        input logic [axi_wr_pkg::LEN_W-1:0]   got_len,
        input logic [axi_wr_pkg::LEN_W-1:0]   exp_len,
        input logic [axi_wr_pkg::SIZE_W-1:0]  got_size,
        input logic [axi_wr_pkg::SIZE_W-1:0]  exp_size,
        input logic [axi_wr_pkg::BURST_W-1:0] got_burst,
        input logic [axi_wr_pkg::BURST_W-1:0] exp_burst
    );
        if (got_addr !== exp_addr || got_data !== exp_data || got_strb !== exp_strb ||
            got_last !== exp_last || got_id !== exp_id || got_len !== exp_len ||
            got_size !== exp_size || got_burst !== exp_burst)
            report_mismatch({
                $sformatf("beat addr %h/%h data %h/%h strb %h/%h last %b/%b ",
                          got_addr, exp_addr, got_data, exp_data, got_strb, exp_strb,
                          got_last, exp_last),
                $sformatf("id %h/%h len %h/%h size %h/%h burst %h/%h (got/expected)",
                          got_id, exp_id, got_len, exp_len, got_size, exp_size,
                          got_burst, exp_burst)});
    endtask

    task automatic check_resp(input axi_wr_pkg::b_entry_t got, input axi_wr_pkg::b_entry_t exp);
        if (got !== exp)
            report_mismatch($sformatf("response bid %h bresp %h, expected bid %h bresp %h",
                                      got.id, got.resp, exp.id, exp.resp));
    endtask

    // ------------------------------
    // Case file
    // ------------------------------
    // Each record holds id addr len size burst resp, then data strb beat_addr per beat
    task automatic load_cases();
        axi_wr_pkg::aw_entry_t aw;
        axi_wr_pkg::w_entry_t  wd;
        axi_wr_pkg::b_entry_t  rsp;
        int idx;
        int r;
        int k;
        int beats;
        $readmemh("verif/wr_cases.txt", case_words);
        if ($isunknown(case_words[0]) || case_words[0] == 32'd0) begin
            fail_run("case file verif/wr_cases.txt is missing or holds no records");
        end else begin
            n_cases = int'(case_words[0]);
            idx = 1;
            for (r = 0; r < n_cases; r++) begin
                aw.id    = case_words[idx][axi_wr_pkg::ID_W-1:0];
                aw.addr  = case_words[idx+1][axi_wr_pkg::ADDR_W-1:0];
                aw.len   = case_words[idx+2][axi_wr_pkg::LEN_W-1:0];
                aw.size  = case_words[idx+3][axi_wr_pkg::SIZE_W-1:0];
                aw.burst = case_words[idx+4][axi_wr_pkg::BURST_W-1:0];
                rsp.id   = aw.id;
                rsp.resp = case_words[idx+5][axi_wr_pkg::RESP_W-1:0];
                aw_stim_q.push_back(aw);
                exp_resp_q.push_back(rsp);
                // AWLEN counts beats minus one
                beats = int'(aw.len) + 1;
                idx = idx + 6;
                for (k = 0; k < beats; k++) begin
                    wd.data = case_words[idx][axi_wr_pkg::DATA_W-1:0];
                    wd.strb = case_words[idx+1][axi_wr_pkg::STRB_W-1:0];
                    wd.last = (k == beats - 1);
                    w_stim_q.push_back(wd);
                    // Data and strobe pass through to the user port unchanged
                    exp_addr_q.push_back(case_words[idx+2][axi_wr_pkg::ADDR_W-1:0]);
                    exp_data_q.push_back(wd.data);
                    exp_strb_q.push_back(wd.strb);
                    exp_last_q.push_back(wd.last);
                    // Burst fields ride along with every beat
                    exp_id_q.push_back(aw.id);
                    exp_len_q.push_back(aw.len);
                    exp_size_q.push_back(aw.size);
                    exp_burst_q.push_back(aw.burst);
                    idx = idx + 3;
                end
            end
            timeout_limit = 200 * n_cases + 1000;
        end
    endtask

    // ------------------------------
    // AXI drivers
    // ------------------------------
    // Ready is stable between edges, so a high ready at the falling edge means
    // the entry is taken on the next rising edge
    task automatic drive_aw_channel();
        axi_wr_pkg::aw_entry_t ent;
        while (aw_stim_q.size() > 0) begin
            ent = aw_stim_q.pop_front();
            @(negedge clk);
            if ($urandom % 4 == 0) begin
                awvalid = 1'b0;
                @(negedge clk);
            end
            awid    = ent.id;
            awaddr  = ent.addr;
            awlen   = ent.len;
            awsize  = ent.size;
            awburst = ent.burst;
            awvalid = 1'b1;
            while (!awready) @(negedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic drive_w_channel();
        axi_wr_pkg::w_entry_t ent;
        while (w_stim_q.size() > 0) begin
            ent = w_stim_q.pop_front();
            @(negedge clk);
            if ($urandom % 4 == 0) begin
                wvalid = 1'b0;
                @(negedge clk);
            end
            wdata  = ent.data;
            wstrb  = ent.strb;
            wlast  = ent.last;
            wvalid = 1'b1;
            while (!wready) @(negedge clk);
        end
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    // User grant and B ready are random after reset
    initial begin
        grant  = 1'b0;
        bready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            grant = ($urandom % 4) != 0;
            // Every third 96-cycle window holds bready low so B, then W and AW back up
            if ((cycle_cnt / 96) % 3 == 0)
                bready = 1'b0;
            else
                bready = ($urandom % 3) != 0;
        end
    end

    // ------------------------------
    // Monitors and timeout
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (!awready)
                aw_stall_seen = 1'b1;
            if (!wready)
                w_stall_seen = 1'b1;
            if (we && !grant)
                report_mismatch("we high while grant is low");
            if (we) begin
                if (exp_addr_q.size() == 0)
                    fail_run("the user port wrote a beat that no case expects");
                else
                    check_beat(addr, exp_addr_q.pop_front(), data, exp_data_q.pop_front(),
                               strb, exp_strb_q.pop_front(), last, exp_last_q.pop_front(),
                               id, exp_id_q.pop_front(), len, exp_len_q.pop_front(),
                               size, exp_size_q.pop_front(), burst, exp_burst_q.pop_front());
            end
            if (bvalid && bready) begin
                if (exp_resp_q.size() == 0)
                    fail_run("the B channel returned a response that no case expects");
                else
                    check_resp({bid, bresp}, exp_resp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit)
            fail_run($sformatf("the run timed out after %0d clock cycles", timeout_limit));
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(97));
        rst_n   = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        load_cases();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fork
            drive_aw_channel();
            drive_w_channel();
        join
        while (exp_addr_q.size() != 0 || exp_resp_q.size() != 0) @(negedge clk);
        // A quiet tail lets the monitor catch any extra beat or response
        repeat (10) @(negedge clk);
        if (!aw_stall_seen || !w_stall_seen)
            fail_run("back-pressure never pulled awready and wready low");
        else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: verif/wr_cases.txt
// Word 0 is the record count; each record is one burst, all values in hex
// Record: id addr len size burst resp, then data strb beat_addr for each beat
0c
// Single beat INCR
1 0100 00 2 1 0  deadbeef f 0100
// Unaligned narrow INCR
2 0203 03 1 1 0  11223344 8 0203  55667788 3 0204
                 99aabbcc c 0206  ddeeff00 3 0208
// FIXED, unaligned start
3 0411 02 2 0 0  a5a5a5a5 f 0411  5a5a5a5a 3 0410  0f0f0f0f c 0410
// INCR that reaches the 4 KB bound
4 0ff8 03 2 1 0  00000001 f 0ff8  00000002 f 0ffc  00000003 f 0ffc  00000004 f 0ffc
// Oversized beats get SLVERR
5 0020 01 3 1 2  cafef00d f 0020  f00dcafe f 0028
6 1234 01 0 2 0  000000ab 1 1234  0000ab00 2 1235
7 0030 00 4 1 2  12345678 f 0030
8 2ffe 02 0 1 0  00aa0000 4 2ffe  bb000000 8 2fff  cc000000 8 2fff
// Long INCR burst
9 0500 07 2 1 0  01010101 f 0500  02020202 f 0504  03030303 f 0508  04040404 f 050c
                 05050505 f 0510  06060606 f 0514  07070707 f 0518  08080808 f 051c
a 0601 01 2 0 0  0000ff00 e 0601  ffffffff f 0600
b 7ffc 01 2 1 0  76543210 f 7ffc  fedcba98 f 7ffc
0 0333 02 0 1 0  44000000 8 0333  00000055 1 0334  00006600 2 0335

// File: verilog/axi_wr_pkg.sv
// Shared widths, buffer depths, AXI codes and buffer entry types of the AXI write slave
package axi_wr_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int DATA_W  = 32;
    // One strobe bit per byte lane
    localparam int STRB_W  = DATA_W / 8;
    localparam int ADDR_W  = 16;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Largest legal AWSIZE, log2 of the byte lanes
    localparam logic [SIZE_W-1:0] MAX_SIZE = SIZE_W'($clog2(STRB_W));

    // ------------------------------
    // Buffer depths
    // ------------------------------
    // Outstanding addresses
    localparam int AW_DEPTH = 4;
    // Write data beats
    localparam int W_DEPTH  = 16;
    // Pending responses
    localparam int B_DEPTH  = 4;

    // Address bit that changes when a burst leaves its 4 KB page
    localparam int PAGE_BIT = 12;

    // ------------------------------
    // AXI codes
    // ------------------------------
    // WRAP and reserved codes are treated like INCR
    localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
    localparam logic [BURST_W-1:0] BURST_INCR  = 2'd1;

    // EXOKAY and DECERR are never returned
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

    // ------------------------------
    // Buffer entries
    // ------------------------------
    // One accepted write address
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } aw_entry_t;

    // One accepted write data beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_entry_t;

    // One pending write response
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
    } b_entry_t;

    // Burst controller phases
    // FIRST takes the address entry with the first beat, BURST the remaining beats
    typedef enum logic [1:0] {
        FIRST,
        BURST,
        RESP_WAIT,
        IDLE
    } burst_phase_t;

endpackage

// File: verilog/axi_wr_slave.sv
// AXI4 write slave top with address, data and response buffers in front of the burst controller
module axi_wr_slave (
    input  logic                            clk,
    input  logic                            rst_n,
    // AW channel
    input  logic [axi_wr_pkg::ID_W-1:0]     awid,
    input  logic [axi_wr_pkg::ADDR_W-1:0]   awaddr,
    input  logic [axi_wr_pkg::LEN_W-1:0]    awlen,
    input  logic [axi_wr_pkg::SIZE_W-1:0]   awsize,
    input  logic [axi_wr_pkg::BURST_W-1:0]  awburst,
    input  logic                            awvalid,
    output logic                            awready,
    // W channel
    input  logic [axi_wr_pkg::DATA_W-1:0]   wdata,
    input  logic [axi_wr_pkg::STRB_W-1:0]   wstrb,
    input  logic                            wlast,
    input  logic                            wvalid,
    output logic                            wready,
    // B channel
    output logic [axi_wr_pkg::ID_W-1:0]     bid,
    output logic [axi_wr_pkg::RESP_W-1:0]   bresp,
    output logic                            bvalid,
    input  logic                            bready,
    // User memory port
    input  logic                            grant,
    output logic                            we,
    output logic                            last,
    output logic [axi_wr_pkg::ADDR_W-1:0]   addr,
    output logic [axi_wr_pkg::DATA_W-1:0]   data,
    output logic [axi_wr_pkg::STRB_W-1:0]   strb,
    output logic [axi_wr_pkg::ID_W-1:0]     id,
    output logic [axi_wr_pkg::LEN_W-1:0]    len,
    output logic [axi_wr_pkg::SIZE_W-1:0]   size,
    output logic [axi_wr_pkg::BURST_W-1:0]  burst
);

    axi_wr_pkg::aw_entry_t aw_din, aw_head;
    axi_wr_pkg::w_entry_t  w_din, w_head;
    axi_wr_pkg::b_entry_t  b_din, b_head;
    logic aw_full, aw_empty, aw_pop;
    logic w_full, w_empty, w_pop;
    logic b_full, b_empty, b_push;

    // ------------------------------
    // AXI handshakes
    // ------------------------------
    assign awready = !aw_full;
    assign wready  = !w_full;
    assign bvalid  = !b_empty;

    assign aw_din = '{id: awid, addr: awaddr, len: awlen, size: awsize, burst: awburst};
    assign w_din  = '{data: wdata, strb: wstrb, last: wlast};
    assign bid    = b_head.id;
    assign bresp  = b_head.resp;

    // ------------------------------
    // Channel buffers
    // ------------------------------
    sync_fifo #(.DEPTH(axi_wr_pkg::AW_DEPTH), .payload_t(axi_wr_pkg::aw_entry_t)) aw_buffer (
        .clk (clk), .rst_n (rst_n),
        .push (awvalid && awready), .pop (aw_pop),
        .din (aw_din), .dout (aw_head), .full (aw_full), .empty (aw_empty)
    );

    sync_fifo #(.DEPTH(axi_wr_pkg::W_DEPTH), .payload_t(axi_wr_pkg::w_entry_t)) w_buffer (
        .clk (clk), .rst_n (rst_n),
        .push (wvalid && wready), .pop (w_pop),
        .din (w_din), .dout (w_head), .full (w_full), .empty (w_empty)
    );

    // Response popped by the master handshake
    sync_fifo #(.DEPTH(axi_wr_pkg::B_DEPTH), .payload_t(axi_wr_pkg::b_entry_t)) b_buffer (
        .clk (clk), .rst_n (rst_n),
        .push (b_push), .pop (bvalid && bready),
        .din (b_din), .dout (b_head), .full (b_full), .empty (b_empty)
    );

    wr_burst_ctrl wr_burst_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_head  (aw_head),
        .aw_empty (aw_empty),
        .aw_pop   (aw_pop),
        .w_head   (w_head),
        .w_empty  (w_empty),
        .w_pop    (w_pop),
        .b_full   (b_full),
        .b_push   (b_push),
        .b_din    (b_din),
        .grant    (grant),
        .we       (we),
        .last     (last),
        .addr     (addr),
        .data     (data),
        .strb     (strb),
        .id       (id),
        .len      (len),
        .size     (size),
        .burst    (burst)
    );

endmodule

// File: verilog/burst_addr_gen.sv
// Beat address generator for FIXED and INCR bursts with size alignment and a 4 KB page bound
module burst_addr_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [axi_wr_pkg::ADDR_W-1:0]      start_addr,
    input  logic [axi_wr_pkg::SIZE_W-1:0]      size,
    input  logic [axi_wr_pkg::BURST_W-1:0]     burst,
    input  logic                               first,
    input  logic                               step,
    output logic [axi_wr_pkg::ADDR_W-1:0]      beat_addr
);

    // ------------------------------
    // Address arithmetic
    // ------------------------------
    logic [axi_wr_pkg::ADDR_W-1:0] aligned_addr;
    logic [axi_wr_pkg::ADDR_W-1:0] addr_inc;
    logic [axi_wr_pkg::ADDR_W-1:0] base_addr;
    logic [axi_wr_pkg::ADDR_W-1:0] cand_addr;
    logic [axi_wr_pkg::ADDR_W-1:0] next_addr;
    logic [axi_wr_pkg::ADDR_W-1:0] addr_q;
    logic                          page_cross;

    // Clear the low size bits of the start address
    assign aligned_addr = start_addr & ({axi_wr_pkg::ADDR_W{1'b1}} << size);

    // Bytes per beat, none for FIXED
    always_comb begin
        if (burst == axi_wr_pkg::BURST_FIXED)
            addr_inc = '0;
        else
            addr_inc = {{(axi_wr_pkg::ADDR_W-1){1'b0}}, 1'b1} << size;
    end

    // Second beat steps from the aligned start, later beats from the last beat
    assign base_addr = first ? aligned_addr : addr_q;
    assign cand_addr = base_addr + addr_inc;

    // Page bit flip means the burst would leave its 4 KB page
    // (also catches a wrap past the top of the address space)
    assign page_cross = cand_addr[axi_wr_pkg::PAGE_BIT] != start_addr[axi_wr_pkg::PAGE_BIT];

    // Hold the last in-page value once the bound is hit
    assign next_addr = page_cross ? base_addr : cand_addr;

    // ------------------------------
    // Beat address register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (step) begin
            addr_q <= next_addr;
        end
    end

    // First beat keeps the master's address, unaligned or not
    assign beat_addr = first ? start_addr : addr_q;

    // Size comes from the AW buffer head or the controller latch
    a_step_size_known: assert property (
        @(posedge clk) disable iff (!rst_n) step |-> !$isunknown(size)
    ) else $error("burst_addr_gen step with undefined size");

endmodule

// File: verilog/sync_fifo.sv
// Single-clock circular buffer with registered full/empty flags and a typed payload
module sync_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t din,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    payload_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic [$clog2(DEPTH+1)-1:0]   count_nxt;

    // Head entry is read straight from the array
    assign dout = mem[rd_ptr];

    // Storage write, data only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH-1 so non power of two depths work too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1))
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1))
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------
    // Occupancy and flags
    // ------------------------------
    always_comb begin
        count_nxt = count;
        if (push && !pop)
            count_nxt = count + 1'b1;
        else if (pop && !push)
            count_nxt = count - 1'b1;
    end

    // Flags come from the next count, so they change with the count itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            count <= count_nxt;
            full  <= (count_nxt == ($clog2(DEPTH+1))'(DEPTH));
            empty <= (count_nxt == '0);
        end
    end

    // Writers and readers sit in other modules and must honour the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("sync_fifo push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("sync_fifo pop while empty");

endmodule

// File: verilog/wr_burst_ctrl.sv
// Burst controller that replays buffered AXI writes beat by beat and queues one response per burst
module wr_burst_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  axi_wr_pkg::aw_entry_t           aw_head,
    input  logic                            aw_empty,
    output logic                            aw_pop,
    input  axi_wr_pkg::w_entry_t            w_head,
    input  logic                            w_empty,
    output logic                            w_pop,
    input  logic                            b_full,
    output logic                            b_push,
    output axi_wr_pkg::b_entry_t            b_din,
    input  logic                            grant,
    output logic                            we,
    output logic                            last,
    output logic [axi_wr_pkg::ADDR_W-1:0]   addr,
    output logic [axi_wr_pkg::DATA_W-1:0]   data,
    output logic [axi_wr_pkg::STRB_W-1:0]   strb,
    output logic [axi_wr_pkg::ID_W-1:0]     id,
    output logic [axi_wr_pkg::LEN_W-1:0]    len,
    output logic [axi_wr_pkg::SIZE_W-1:0]   size,
    output logic [axi_wr_pkg::BURST_W-1:0]  burst
);

    axi_wr_pkg::burst_phase_t        phase;
    axi_wr_pkg::burst_phase_t        phase_nxt;
    logic [axi_wr_pkg::ID_W-1:0]     id_q;
    logic [axi_wr_pkg::ADDR_W-1:0]   addr_q;
    logic [axi_wr_pkg::LEN_W-1:0]    len_q;
    logic [axi_wr_pkg::SIZE_W-1:0]   size_q;
    logic [axi_wr_pkg::BURST_W-1:0]  burst_q;
    logic [axi_wr_pkg::LEN_W-1:0]    beat_cnt;
    logic [axi_wr_pkg::ADDR_W-1:0]   start_addr;
    logic                            first;
    logic                            beat_ready;
    logic                            final_beat;
    logic                            burst_done;

    // ------------------------------
    // Current burst fields
    // ------------------------------
    // FIRST reads the AW head directly, other phases the latched copy
    assign first      = (phase == axi_wr_pkg::FIRST);
    assign id         = first ? aw_head.id    : id_q;
    assign len        = first ? aw_head.len   : len_q;
    assign size       = first ? aw_head.size  : size_q;
    assign burst      = first ? aw_head.burst : burst_q;
    assign start_addr = first ? aw_head.addr  : addr_q;

    // A beat needs address and data in FIRST, only data in BURST
    assign beat_ready = (first && !aw_empty && !w_empty) ||
                        (phase == axi_wr_pkg::BURST && !w_empty);

    // Grant is the only back-pressure from the user side
    assign we     = beat_ready && grant;
    assign aw_pop = we && first;
    assign w_pop  = we;

    assign final_beat = first ? (len == '0) : (beat_cnt == len);
    assign burst_done = we && final_beat;
    assign last       = burst_done;
    assign data       = w_head.data;
    assign strb       = w_head.strb;

    // Response on the last beat, or later once B has room
    assign b_push = !b_full && (burst_done || phase == axi_wr_pkg::RESP_WAIT);
    assign b_din  = '{id: id,
                      resp: (size > axi_wr_pkg::MAX_SIZE) ? axi_wr_pkg::RESP_SLVERR
                                                          : axi_wr_pkg::RESP_OKAY};

    // ------------------------------
    // Phase FSM
    // ------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            axi_wr_pkg::IDLE:      phase_nxt = axi_wr_pkg::FIRST;
            axi_wr_pkg::FIRST,
            axi_wr_pkg::BURST: begin
                if (burst_done)
                    phase_nxt = b_full ? axi_wr_pkg::RESP_WAIT : axi_wr_pkg::FIRST;
                else if (we)
                    phase_nxt = axi_wr_pkg::BURST;
            end
            axi_wr_pkg::RESP_WAIT: if (!b_full) phase_nxt = axi_wr_pkg::FIRST;
            default:               phase_nxt = axi_wr_pkg::IDLE;
        endcase
    end

    // Beat counter holds the index of the next beat within the burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= axi_wr_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            phase <= phase_nxt;
            if (we)
                beat_cnt <= first ? {{(axi_wr_pkg::LEN_W-1){1'b0}}, 1'b1} : beat_cnt + 1'b1;
        end
    end

    // Address entry latched as it leaves the AW buffer
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            id_q    <= aw_head.id;
            addr_q  <= aw_head.addr;
            len_q   <= aw_head.len;
            size_q  <= aw_head.size;
            burst_q <= aw_head.burst;
        end
    end

    burst_addr_gen burst_addr_gen_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_addr (start_addr),
        .size       (size),
        .burst      (burst),
        .first      (first),
        .step       (we),
        .beat_addr  (addr)
    );

    a_phase_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(phase))
        else $error("wr_burst_ctrl phase undefined");
    // Master's WLAST must agree with AWLEN
    a_wlast_match: assert property (@(posedge clk) disable iff (!rst_n) we |-> w_head.last == last)
        else $error("wr_burst_ctrl WLAST disagrees with burst length");

endmodule
